// File: logic/console_map_pkg.sv
`default_nettype none

package console_map_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  bus_byte_t;
    typedef logic [7:0]  vram_addr_t;
    typedef logic [7:0]  rom_addr_t;

    // external RAM starts at address zero
    localparam cpu_addr_t ram_limit = 16'h36FF;

    localparam int        vram_size  = 256;
    localparam cpu_addr_t vram_base  = 16'h3700;
    localparam cpu_addr_t vram_limit = vram_base + cpu_addr_t'(vram_size - 1);

    // single-byte registers in the FPGA
    localparam cpu_addr_t in_vblank_addr      = 16'h3800;
    localparam cpu_addr_t clr_vblank_irq_addr = 16'h3801;
    localparam cpu_addr_t pad1_addr           = 16'h3802;
    localparam cpu_addr_t pad2_addr           = 16'h3803;

    localparam cpu_addr_t rom_base  = 16'h4000;
    localparam cpu_addr_t rom_limit = 16'hEFFF;

    localparam int        firmware_size  = 256;
    localparam cpu_addr_t firmware_base  = 16'hF000;
    localparam cpu_addr_t firmware_limit = firmware_base + cpu_addr_t'(firmware_size - 1);

    // the vector region runs up to the top of the address space
    localparam cpu_addr_t vectors_base = 16'hFFF0;

    // vectors come from the last 16 bytes of the firmware ROM
    localparam rom_addr_t vector_rom_base = 8'hF0;

endpackage

`default_nettype wire

// File: logic/video_pkg.sv
`default_nettype none

package video_pkg;

    typedef logic [9:0] h_count_t;
    typedef logic [9:0] v_count_t;
    typedef logic [1:0] colour_t;

    // one pixel clock per column, so a line is 400 clocks at 12.5875 MHz
    localparam h_count_t h_visible   = 10'd320;
    localparam h_count_t h_total     = 10'd400;
    localparam h_count_t hsync_start = 10'd336;
    localparam h_count_t hsync_end   = 10'd383;

    localparam v_count_t v_visible   = 10'd480;
    localparam v_count_t v_total     = 10'd525;
    localparam v_count_t vsync_start = 10'd490;
    localparam v_count_t vsync_end   = 10'd491;

    // each VRAM byte paints one cell, giving a 16 x 16 grid on screen
    localparam h_count_t cell_width  = 10'd20;
    localparam v_count_t cell_height = 10'd30;

endpackage

`default_nettype wire

// File: logic/address_decoder.sv
`default_nettype none

module address_decoder import console_map_pkg::*; (
    input  cpu_addr_t cpu_address,
    output logic      sel_ram,
    output logic      sel_rom,
    output logic      sel_vram,
    output logic      sel_firmware,
    output logic      sel_vectors,
    output logic      sel_in_vblank,
    output logic      sel_clr_vblank_irq,
    output logic      sel_pad1,
    output logic      sel_pad2
);

    // external chips
    assign sel_ram = (cpu_address <= ram_limit);
    assign sel_rom = (cpu_address >= rom_base) && (cpu_address <= rom_limit);

    assign sel_vram = (cpu_address >= vram_base) && (cpu_address <= vram_limit);

    assign sel_in_vblank      = (cpu_address == in_vblank_addr);
    assign sel_clr_vblank_irq = (cpu_address == clr_vblank_irq_addr);
    assign sel_pad1           = (cpu_address == pad1_addr);
    assign sel_pad2           = (cpu_address == pad2_addr);

    // F100 to FFEF is left unmapped
    assign sel_firmware = (cpu_address >= firmware_base) && (cpu_address <= firmware_limit);
    assign sel_vectors  = (cpu_address >= vectors_base);

    // overlapping regions would put two drivers on the data bus
    selects_one_hot : assert final ($onehot0({
        sel_ram,
        sel_rom,
        sel_vram,
        sel_firmware,
        sel_vectors,
        sel_in_vblank,
        sel_clr_vblank_irq,
        sel_pad1,
        sel_pad2
    }));

endmodule

`default_nettype wire

// File: logic/firmware_rom.sv
`default_nettype none

module firmware_rom import console_map_pkg::*; (
    input  cpu_addr_t cpu_address,
    input  logic      sel_firmware,
    input  logic      sel_vectors,
    output bus_byte_t rdata
);

    bus_byte_t rom [firmware_size];
    rom_addr_t rom_offset;

    initial begin
        $readmemh("firmware.hex", rom);
    end

    // FFFx lands on F0x so the reset and irq vectors live in the image
    always_comb begin
        if (sel_vectors) begin
            rom_offset = vector_rom_base | rom_addr_t'(cpu_address[3:0]);
        end else begin
            rom_offset = rom_addr_t'(cpu_address - firmware_base);
        end
    end

    assign rdata = (sel_firmware || sel_vectors) ? rom[rom_offset] : '0;

endmodule

`default_nettype wire

// File: logic/video_controller.sv
`default_nettype none

module video_controller import console_map_pkg::*, video_pkg::*; (
    input  logic      clk_12_5875,
    input  logic      rst_n,
    input  cpu_addr_t cpu_address,
    input  bus_byte_t data_in,
    input  logic      write_enable,
    input  logic      sel_vram,
    input  logic      sel_in_vblank,
    input  logic      sel_clr_vblank_irq,
    output bus_byte_t rdata,
    output colour_t   r,
    output colour_t   g,
    output colour_t   b,
    output logic      hsync,
    output logic      vsync,
    output logic      vblank_irq,
    output logic      pad_fetch
);

    h_count_t   h_count;
    v_count_t   v_count;
    bus_byte_t  vram [vram_size];
    vram_addr_t cpu_offset;
    vram_addr_t cell_addr;
    h_count_t   cell_col;
    v_count_t   cell_row;
    bus_byte_t  cell_byte;
    logic       line_end;
    logic       in_vblank;
    logic       visible;
    logic       vblank_start;

    assign line_end = (h_count == h_total - 10'd1);

    always_ff @(posedge clk_12_5875) begin
        if (!rst_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            v_count <= (v_count == v_total - 10'd1) ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign in_vblank    = (v_count >= v_visible);
    assign vblank_start = (h_count == '0) && (v_count == v_visible); // first pixel of line 480
    assign visible      = (h_count < h_visible) && !in_vblank;

    // outside the visible area the cell index wraps, but the pixel is blanked anyway
    assign cell_col  = h_count / cell_width;
    assign cell_row  = v_count / cell_height;
    assign cell_addr = {cell_row[3:0], cell_col[3:0]};
    assign cell_byte = vram[cell_addr];

    assign cpu_offset = vram_addr_t'(cpu_address - vram_base);

    always_ff @(posedge clk_12_5875) begin
        if (write_enable && sel_vram) begin
            vram[cpu_offset] <= data_in;
        end
    end

    always_comb begin
        if (sel_vram) begin
            rdata = vram[cpu_offset];
        end else if (sel_in_vblank) begin
            rdata = {7'd0, in_vblank};
        end else begin
            rdata = '0;
        end
    end

    // syncs and colour are registered together so they stay aligned on the monitor
    always_ff @(posedge clk_12_5875) begin
        if (!rst_n) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            r     <= '0;
            g     <= '0;
            b     <= '0;
        end else begin
            hsync <= (h_count >= hsync_start) && (h_count <= hsync_end);
            vsync <= (v_count >= vsync_start) && (v_count <= vsync_end);
            r     <= visible ? cell_byte[5:4] : 2'b00;
            g     <= visible ? cell_byte[3:2] : 2'b00;
            b     <= visible ? cell_byte[1:0] : 2'b00;
        end
    end

    always_ff @(posedge clk_12_5875) begin
        if (!rst_n) begin
            vblank_irq <= 1'b0;
            pad_fetch  <= 1'b0;
        end else begin
            pad_fetch <= vblank_start;
            if (vblank_start) begin
                vblank_irq <= 1'b1; // a new frame beats a clear in the same cycle
            end else if (write_enable && sel_clr_vblank_irq) begin
                vblank_irq <= 1'b0;
            end
        end
    end

    // the pad reader arms once per frame and must not see a held level
    pad_fetch_single : assert property (
        @(posedge clk_12_5875) disable iff (!rst_n) pad_fetch |=> !pad_fetch
    );

endmodule

`default_nettype wire

// File: logic/pad_reader.sv
`default_nettype none

module pad_reader import console_map_pkg::*; #(
    parameter int num_pads = 2
) (
    input  logic                     clk_12_5875,
    input  logic                     rst_n,
    input  logic                     slow_clk_enable,
    input  logic                     pad_fetch,
    input  logic      [num_pads-1:0] pad_data_b,
    output logic                     pad_latch,
    output logic                     pad_clk_enable,
    output bus_byte_t [num_pads-1:0] buttons
);

    typedef enum logic [1:0] {
        st_idle,
        st_latch,
        st_shift,
        st_done
    } pad_state_t;

    pad_state_t                state;
    logic      [2:0]           bit_count;
    bus_byte_t [num_pads-1:0]  shift_q;

    always_ff @(posedge clk_12_5875) begin
        if (!rst_n) begin
            state          <= st_idle;
            bit_count      <= '0;
            pad_latch      <= 1'b0;
            pad_clk_enable <= 1'b0;
            buttons        <= '0;
        end else begin
            pad_clk_enable <= 1'b0;
            case (state)
                st_idle: begin
                    if (pad_fetch) begin
                        state <= st_latch;
                    end
                end
                // latch rises on one strobe and falls on the next
                st_latch: begin
                    if (slow_clk_enable) begin
                        pad_latch <= !pad_latch;
                        if (pad_latch) begin
                            state <= st_shift;
                        end
                    end
                end
                st_shift: begin
                    if (slow_clk_enable) begin
                        pad_clk_enable <= 1'b1;
                        bit_count      <= bit_count + 1'b1;
                        if (bit_count == 3'd7) begin
                            state <= st_done;
                        end
                    end
                end
                st_done: begin
                    for (int i = 0; i < num_pads; i++) begin
                        buttons[i] <= ~shift_q[i]; // pressed reads as 1
                    end
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // the pad shifts on the clock pulse, so sampling on the same edge takes the current bit
    always_ff @(posedge clk_12_5875) begin
        if (state == st_shift && slow_clk_enable) begin
            for (int i = 0; i < num_pads; i++) begin
                shift_q[i] <= {shift_q[i][6:0], pad_data_b[i]};
            end
        end
    end

    latch_excludes_clock : assert property (
        @(posedge clk_12_5875) disable iff (!rst_n) !(pad_latch && pad_clk_enable)
    );

endmodule

`default_nettype wire

// File: logic/console_top.sv
`default_nettype none

module console_top import console_map_pkg::*, video_pkg::*; (
    input  logic      clk_12_5875,
    input  logic      rst_n,
    input  logic      slow_clk_enable,
    input  cpu_addr_t cpu_address,
    input  bus_byte_t data_in,
    input  logic      write_enable_b,
    input  logic      pad1_data_b,
    input  logic      pad2_data_b,
    output bus_byte_t data_out,
    output logic      fpga_data_enable,
    output logic      sel_ram_b,
    output logic      ram_oe_b,
    output logic      sel_rom_b,
    output logic      vblank_irq_b,
    output colour_t   r,
    output colour_t   g,
    output colour_t   b,
    output logic      hsync,
    output logic      vsync,
    output logic      pad_clk_enable,
    output logic      pad_latch,
    output bus_byte_t pad1_buttons,
    output bus_byte_t pad2_buttons
);

    localparam int num_pads = 2;

    logic      sel_ram;
    logic      sel_rom;
    logic      sel_vram;
    logic      sel_firmware;
    logic      sel_vectors;
    logic      sel_in_vblank;
    logic      sel_clr_vblank_irq;
    logic      sel_pad1;
    logic      sel_pad2;
    logic      write_enable;
    logic      vblank_irq;
    logic      pad_fetch;
    logic      internal_read;
    bus_byte_t rom_rdata;
    bus_byte_t video_rdata;
    bus_byte_t [num_pads-1:0] pad_buttons;

    assign write_enable = !write_enable_b;

    assign sel_ram_b    = !sel_ram;
    assign sel_rom_b    = !sel_rom;
    assign vblank_irq_b = !vblank_irq;
    assign ram_oe_b     = !(sel_ram && write_enable_b); // RAM drives the bus only on reads

    assign pad1_buttons = pad_buttons[0];
    assign pad2_buttons = pad_buttons[1];

    assign internal_read = sel_firmware || sel_vectors || sel_vram || sel_in_vblank
                         || sel_pad1 || sel_pad2;
    assign fpga_data_enable = write_enable_b && internal_read;

    always_comb begin
        if (sel_firmware || sel_vectors) begin
            data_out = rom_rdata;
        end else if (sel_vram || sel_in_vblank) begin
            data_out = video_rdata;
        end else if (sel_pad1) begin
            data_out = pad_buttons[0];
        end else if (sel_pad2) begin
            data_out = pad_buttons[1];
        end else begin
            data_out = '0;
        end
    end

    address_decoder address_decoder_i (
        .cpu_address        (cpu_address),
        .sel_ram            (sel_ram),
        .sel_rom            (sel_rom),
        .sel_vram           (sel_vram),
        .sel_firmware       (sel_firmware),
        .sel_vectors        (sel_vectors),
        .sel_in_vblank      (sel_in_vblank),
        .sel_clr_vblank_irq (sel_clr_vblank_irq),
        .sel_pad1           (sel_pad1),
        .sel_pad2           (sel_pad2)
    );

    firmware_rom firmware_rom_i (
        .cpu_address  (cpu_address),
        .sel_firmware (sel_firmware),
        .sel_vectors  (sel_vectors),
        .rdata        (rom_rdata)
    );

    video_controller video_controller_i (
        .clk_12_5875        (clk_12_5875),
        .rst_n              (rst_n),
        .cpu_address        (cpu_address),
        .data_in            (data_in),
        .write_enable       (write_enable),
        .sel_vram           (sel_vram),
        .sel_in_vblank      (sel_in_vblank),
        .sel_clr_vblank_irq (sel_clr_vblank_irq),
        .rdata              (video_rdata),
        .r                  (r),
        .g                  (g),
        .b                  (b),
        .hsync              (hsync),
        .vsync              (vsync),
        .vblank_irq         (vblank_irq),
        .pad_fetch          (pad_fetch)
    );

    pad_reader #(
        .num_pads (num_pads)
    ) pad_reader_i (
        .clk_12_5875     (clk_12_5875),
        .rst_n           (rst_n),
        .slow_clk_enable (slow_clk_enable),
        .pad_fetch       (pad_fetch),
        .pad_data_b      ({pad2_data_b, pad1_data_b}),
        .pad_latch       (pad_latch),
        .pad_clk_enable  (pad_clk_enable),
        .buttons         (pad_buttons)
    );

endmodule

`default_nettype wire

// File: testbench/console_tb.sv
`default_nettype none

module console_tb import console_map_pkg::*, video_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 300000;
    localparam int max_vectors    = 64;
    localparam int strobe_period  = 8;

    logic      clk_12_5875 = 1'b0;
    logic      rst_n;
    logic      slow_clk_enable;
    cpu_addr_t cpu_address;
    bus_byte_t data_in;
    logic      write_enable_b;
    logic      pad1_data_b;
    logic      pad2_data_b;
    bus_byte_t data_out;
    logic      fpga_data_enable;
    logic      sel_ram_b;
    logic      ram_oe_b;
    logic      sel_rom_b;
    logic      vblank_irq_b;
    colour_t   r;
    colour_t   g;
    colour_t   b;
    logic      hsync;
    logic      vsync;
    logic      pad_clk_enable;
    logic      pad_latch;
    bus_byte_t pad1_buttons;
    bus_byte_t pad2_buttons;

    logic [39:0] vectors [max_vectors];
    bus_byte_t   pad1_line_byte; // raw active-low byte, as the pad puts it on the wire
    bus_byte_t   pad2_line_byte;
    bus_byte_t   pad1_shift;
    bus_byte_t   pad2_shift;
    int          strobe_count;
    integer      seed;

    console_top console_top_i (
        .clk_12_5875      (clk_12_5875),
        .rst_n            (rst_n),
        .slow_clk_enable  (slow_clk_enable),
        .cpu_address      (cpu_address),
        .data_in          (data_in),
        .write_enable_b   (write_enable_b),
        .pad1_data_b      (pad1_data_b),
        .pad2_data_b      (pad2_data_b),
        .data_out         (data_out),
        .fpga_data_enable (fpga_data_enable),
        .sel_ram_b        (sel_ram_b),
        .ram_oe_b         (ram_oe_b),
        .sel_rom_b        (sel_rom_b),
        .vblank_irq_b     (vblank_irq_b),
        .r                (r),
        .g                (g),
        .b                (b),
        .hsync            (hsync),
        .vsync            (vsync),
        .pad_clk_enable   (pad_clk_enable),
        .pad_latch        (pad_latch),
        .pad1_buttons     (pad1_buttons),
        .pad2_buttons     (pad2_buttons)
    );

    always #5 clk_12_5875 = !clk_12_5875;

    always @(posedge clk_12_5875) begin
        #1;
        if (strobe_count == strobe_period - 1) begin
            strobe_count    = 0;
            slow_clk_enable = 1'b1;
        end else begin
            strobe_count    = strobe_count + 1;
            slow_clk_enable = 1'b0;
        end
    end

    // both pads load while latch is high and move to the next bit after each clock pulse
    always @(posedge clk_12_5875) begin
        #1;
        if (pad_latch) begin
            pad1_shift = pad1_line_byte;
            pad2_shift = pad2_line_byte;
        end else if (pad_clk_enable) begin
            pad1_shift = {pad1_shift[6:0], 1'b1};
            pad2_shift = {pad2_shift[6:0], 1'b1};
        end
        pad1_data_b = pad1_shift[7];
        pad2_data_b = pad2_shift[7];
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input bus_byte_t expected,
                               input bus_byte_t actual);
        assert (actual === expected) else begin
            report_failure($sformatf("ERROR %s: expected %02h, actual %02h",
                                     name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_12_5875);
        #1;
    endtask

    // the value is taken just before the next rising edge
    task automatic bus_read(input cpu_addr_t addr, output bus_byte_t value);
        next_cycle();
        cpu_address    = addr;
        write_enable_b = 1'b1;
        #8;
        value = data_out;
    endtask

    task automatic bus_write(input cpu_addr_t addr, input bus_byte_t value);
        next_cycle();
        cpu_address    = addr;
        data_in        = value;
        write_enable_b = 1'b0;
        next_cycle();
        write_enable_b = 1'b1;
    endtask

    task automatic wait_irq_low(input string name);
        int cycles;
        cycles = 0;
        while (vblank_irq_b !== 1'b0) begin
            assert (cycles < timeout_cycles) else begin
                report_failure({name, ": the vblank interrupt never went low"});
            end
            next_cycle();
            cycles++;
        end
    endtask

    // the rising vsync output marks column 0 of line vsync_start, so every later pixel
    // shows up a fixed number of clocks after it
    task automatic check_cell_colour(input string name, input vram_addr_t offset,
                                     input bus_byte_t value);
        bus_byte_t expected;
        int        h_pos;
        int        v_pos;
        int        cycles;
        expected = {2'b00, value[5:0]}; // r, g and b sit in bits 5:0 of the cell byte
        h_pos    = int'(offset[3:0]) * int'(cell_width);
        v_pos    = int'(offset[7:4]) * int'(cell_height);
        bus_write(vram_base + cpu_addr_t'(offset), value);
        cycles = 0;
        while (vsync !== 1'b0) begin
            assert (cycles < timeout_cycles) else begin
                report_failure({name, ": vsync never went low"});
            end
            next_cycle();
            cycles++;
        end
        cycles = 0;
        while (vsync !== 1'b1) begin
            assert (cycles < timeout_cycles) else begin
                report_failure({name, ": vsync never went high"});
            end
            next_cycle();
            cycles++;
        end
        repeat ((int'(v_total) - int'(vsync_start) + v_pos) * int'(h_total) + h_pos) begin
            next_cycle();
        end
        check_value({name, " pixel"}, expected, {2'b00, r, g, b});
        check_value({name, " syncs in picture"}, 8'h00, {6'd0, hsync, vsync});
        repeat (int'(hsync_start) - h_pos) begin
            next_cycle();
        end
        check_value({name, " hsync start"}, 8'h02, {6'd0, hsync, vsync});
        check_value({name, " blanked pixel"}, 8'h00, {2'b00, r, g, b});
        repeat (int'(hsync_end) - int'(hsync_start) + 1) begin
            next_cycle();
        end
        check_value({name, " hsync end"}, 8'h00, {6'd0, hsync, vsync});
    endtask

    task automatic run_vector(input int index, input logic [39:0] vec);
        bus_byte_t op;
        cpu_addr_t addr;
        bus_byte_t wdata;
        bus_byte_t expected;
        bus_byte_t value;
        bus_byte_t readback;
        string     name;
        int        cycles;
        op       = vec[39:32];
        addr     = vec[31:16];
        wdata    = vec[15:8];
        expected = vec[7:0];
        name     = $sformatf("vector %0d at %04h", index, addr);
        case (op)
            8'h01: begin
                bus_read(addr, value);
                check_value({name, " read"}, expected, value);
            end
            8'h02: bus_write(addr, wdata);
            8'h03: begin
                wait_irq_low(name);
                bus_read(addr, value);
                check_value({name, " in_vblank"}, expected, value);
                check_value({name, " irq held"}, 8'h00, {7'd0, vblank_irq_b});
            end
            8'h04: begin
                bus_write(addr, 8'h00);
                check_value({name, " irq cleared"}, 8'h01, {7'd0, vblank_irq_b});
                cycles = 0;
                bus_read(in_vblank_addr, value);
                while (value !== expected) begin
                    assert (cycles < timeout_cycles) else begin
                        report_failure({name, ": the raster never left vblank"});
                    end
                    bus_read(in_vblank_addr, value);
                    cycles++;
                end
            end
            8'h05: begin
                pad1_line_byte = addr[15:8];
                pad2_line_byte = addr[7:0];
                value    = pad1_buttons;
                readback = pad2_buttons;
                cycles   = 0;
                while (pad1_buttons === value && pad2_buttons === readback) begin
                    assert (cycles < timeout_cycles) else begin
                        report_failure({name, ": the pad buttons never changed"});
                    end
                    next_cycle();
                    cycles++;
                end
                check_value({name, " irq after vblank"}, 8'h00, {7'd0, vblank_irq_b});
                check_value({name, " pad1_buttons"}, wdata, pad1_buttons);
                check_value({name, " pad2_buttons"}, expected, pad2_buttons);
                bus_read(pad1_addr, value);
                check_value({name, " pad1 read"}, wdata, value);
                bus_read(pad2_addr, value);
                check_value({name, " pad2 read"}, expected, value);
            end
            8'h06: begin
                next_cycle();
                cpu_address    = addr;
                data_in        = 8'h00;
                write_enable_b = !wdata[0];
                #8;
                check_value({name, " decode"}, expected,
                            {4'd0, sel_ram_b, sel_rom_b, fpga_data_enable, ram_oe_b});
                next_cycle();
                write_enable_b = 1'b1;
            end
            8'h07: begin
                value = bus_byte_t'($random(seed));
                bus_write(addr, value);
                bus_read(addr, readback);
                check_value({name, " random vram"}, value, readback);
            end
            default: report_failure($sformatf("%s has an unknown operation code %02h", name, op));
        endcase
    endtask

    initial begin
        rst_n           = 1'b0;
        slow_clk_enable = 1'b0;
        cpu_address     = '0;
        data_in         = '0;
        write_enable_b  = 1'b1;
        pad1_data_b     = 1'b1;
        pad2_data_b     = 1'b1;
        strobe_count    = 0;
        seed            = 26;
        pad1_line_byte  = 8'hFF; // nothing pressed until a pad check loads a byte
        pad2_line_byte  = 8'hFF;
        pad1_shift      = 8'hFF;
        pad2_shift      = 8'hFF;
        for (int i = 0; i < max_vectors; i++) begin
            vectors[i] = '0;
        end
        $readmemh("testbench/console_vectors.txt", vectors);

        repeat (3) @(posedge clk_12_5875);
        #1;
        rst_n = 1'b1;

        check_value("reset vblank_irq_b", 8'h01, {7'd0, vblank_irq_b});
        check_value("reset pad_latch", 8'h00, {7'd0, pad_latch});
        check_value("reset pad_clk_enable", 8'h00, {7'd0, pad_clk_enable});
        check_value("reset pad1_buttons", 8'h00, pad1_buttons);
        check_value("reset pad2_buttons", 8'h00, pad2_buttons);

        // an all-zero word marks the end of the vector list
        for (int i = 0; i < max_vectors; i++) begin
            if (vectors[i][39:32] == 8'h00) begin
                break;
            end
            run_vector(i, vectors[i]);
        end

        // bits 7:6 of a cell byte carry no colour
        check_cell_colour("cell 00", 8'h00, 8'hDB);
        check_cell_colour("cell 4B", 8'h4B, 8'h64);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/console_vectors.txt
// columns: op_address_wdata_expected, hex; op 01 read, 02 write, 03 wait vblank,
// 04 clear irq, 05 pad check, 06 decode flags, 07 random vram byte
// decode flags are {sel_ram_b, sel_rom_b, fpga_data_enable, ram_oe_b}, wdata 01 is a write
06_0000_00_04
06_36FF_00_04
06_36FF_01_05
06_3700_00_0F
06_3804_00_0D
06_3FFF_00_0D
06_4000_00_09
06_EFFF_00_09
06_F000_00_0F
06_F100_00_0D
06_FFF0_00_0F
06_3802_01_0D
01_3800_00_00
01_3802_00_00
01_F000_00_78
01_F010_00_48
01_F035_00_35
01_F0FC_00_00
01_FFF9_00_F9
01_FFFC_00_00
01_FFFD_00_F0
01_FFFE_00_10
01_F100_00_00
02_3700_5A_00
02_37FF_C3_00
01_3700_00_5A
01_37FF_00_C3
02_3742_7E_00
01_3742_00_7E
01_3742_00_7E
07_3710_00_00
07_3788_00_00
03_3800_00_01
04_3801_00_00
// pad check address holds the raw pad1 and pad2 bytes, then the expected buttons
05_A53C_5A_C3
05_0FF0_F0_0F

// File: firmware.hex
78 D8 A2 FF 9A A9 00 8D 01 38 58 4C 0B F0 EA EA
48 AD 02 38 8D 00 02 AD 03 38 8D 01 02 8D 01 38
68 40 A9 3F A2 00 9D 00 37 E8 D0 FA 60 EA EA EA
30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F
40 41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 4F
50 51 52 53 54 55 56 57 58 59 5A 5B 5C 5D 5E 5F
60 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F
70 71 72 73 74 75 76 77 78 79 7A 7B 7C 7D 7E 7F
80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F
90 91 92 93 94 95 96 97 98 99 9A 9B 9C 9D 9E 9F
A0 A1 A2 A3 A4 A5 A6 A7 A8 A9 AA AB AC AD AE AF
B0 B1 B2 B3 B4 B5 B6 B7 B8 B9 BA BB BC BD BE BF
C0 C1 C2 C3 C4 C5 C6 C7 C8 C9 CA CB CC CD CE CF
D0 D1 D2 D3 D4 D5 D6 D7 D8 D9 DA DB DC DD DE DF
E0 E1 E2 E3 E4 E5 E6 E7 E8 E9 EA EB EC ED EE EF
F0 F1 F2 F3 F4 F5 F6 F7 F8 F9 22 F0 00 F0 10 F0

// File: src.f
logic/console_map_pkg.sv
logic/video_pkg.sv
logic/address_decoder.sv
logic/firmware_rom.sv
logic/video_controller.sv
logic/pad_reader.sv
logic/console_top.sv
testbench/console_tb.sv

// File: Bender.yml
package:
  name: console_fpga

sources:
  - logic/console_map_pkg.sv
  - logic/video_pkg.sv
  - logic/address_decoder.sv
  - logic/firmware_rom.sv
  - logic/video_controller.sv
  - logic/pad_reader.sv
  - logic/console_top.sv
  - target: test
    files:
      - testbench/console_tb.sv
